/* hdl/pipePkg.sv */
package pipePkg;

    // Instruction field widths
    localparam int OPCODE_W = 5;
    localparam int REG_W = 3;
    localparam int IMM_W = 5;
    localparam int PC_W = 16;
    localparam int INSTR_W = 16;

    // Latches past ID: EX, MEM and WB
    localparam int NUM_LATCHES = 3;

    // APB bus widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Register map
    localparam logic [APB_ADDR_W-1:0] REG_INSTR = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_RETIRED = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_STALLS = 8'h10;
    // Queue count sits in the low bits of the status word
    localparam int STATUS_HALTED_BIT = 16;

    // Opcodes
    localparam logic [OPCODE_W-1:0] OP_HALT = 5'b00000;
    localparam logic [OPCODE_W-1:0] OP_NOP = 5'b00001;
    localparam logic [OPCODE_W-1:0] OP_JMP = 5'b00100;
    localparam logic [OPCODE_W-1:0] OP_ST = 5'b10000;
    localparam logic [OPCODE_W-1:0] OP_LD = 5'b10001;
    localparam logic [OPCODE_W-1:0] OP_SLBI = 5'b10010;
    localparam logic [OPCODE_W-1:0] OP_LBI = 5'b11000;
    localparam logic [OPCODE_W-1:0] OP_BTR = 5'b11001;
    localparam logic [OPCODE_W-1:0] OP_ADD = 5'b11011;

    // Group prefixes on opcode[4:2]
    localparam logic [2:0] PFX_JMP = 3'b001;
    localparam logic [2:0] PFX_BR = 3'b011;
    localparam logic [2:0] PFX_IMM_A = 3'b010;
    localparam logic [2:0] PFX_IMM_B = 3'b101;

    // Bubble word loaded into empty stages
    localparam logic [INSTR_W-1:0] NOP_WORD = {OP_NOP, {(INSTR_W-OPCODE_W){1'b0}}};

    // Same 16 bits seen as register form or immediate form
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [REG_W-1:0] rd;
            logic [1:0] func;
        } r;
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [IMM_W-1:0] imm;
        } i;
    } instrWord_u;

    // Jumps and branches
    function automatic logic isControl(input logic [OPCODE_W-1:0] op);
        return (op[4:2] == PFX_JMP) || (op[4:2] == PFX_BR);
    endfunction

    // Opcodes that write a register
    function automatic logic writesReg(input logic [OPCODE_W-1:0] op);
        return !((op == OP_HALT) || (op == OP_NOP) || (op == OP_ST) || isControl(op));
    endfunction

    // JMP and JAL carry a displacement where rs would be
    function automatic logic usesRs(input logic [OPCODE_W-1:0] op);
        return !(((op[4:2] == PFX_JMP) && !op[0]) || (op == OP_LBI)
                 || (op == OP_NOP) || (op == OP_HALT));
    endfunction

    // Rt only read by register forms and by ST data
    function automatic logic usesRt(input logic [OPCODE_W-1:0] op);
        return !(isControl(op) || (op[4:2] == PFX_IMM_A) || (op[4:2] == PFX_IMM_B)
                 || (op == OP_LD) || (op == OP_LBI) || (op == OP_SLBI)
                 || (op == OP_BTR) || (op == OP_NOP) || (op == OP_HALT));
    endfunction

endpackage

/* hdl/instrQueue.sv */
`timescale 1ns/1ps

module instrQueue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic clk,
    input  logic reset,
    // APB slave
    input  logic pSel,
    input  logic pEnable,
    input  logic pWrite,
    input  logic [pipePkg::APB_ADDR_W-1:0] pAddr,
    input  logic [pipePkg::APB_DATA_W-1:0] pWdata,
    output logic [pipePkg::APB_DATA_W-1:0] pRdata,
    output logic pReady,
    output logic pSlverr,
    // Fetch side
    input  logic qPop,
    output logic qValid,
    output logic [pipePkg::INSTR_W-1:0] qInstr,
    output logic run,
    // Status from retire
    input  logic [pipePkg::APB_DATA_W-1:0] retiredCount,
    input  logic [pipePkg::APB_DATA_W-1:0] stallCount,
    input  logic halted
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [pipePkg::INSTR_W-1:0] mem [QUEUE_DEPTH];
    // Extra top bit tells full from empty
    logic [PTR_W:0] wrPtr;
    logic [PTR_W:0] rdPtr;
    logic [PTR_W:0] count;
    logic full;
    logic access;
    logic instrWrite;
    logic push;

    assign access = pSel & pEnable;
    // No wait states
    assign pReady = access;

    assign count = wrPtr - rdPtr;
    assign full = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign qValid = (count != '0);
    assign qInstr = mem[rdPtr[PTR_W-1:0]];

    assign instrWrite = access & pWrite & (pAddr == pipePkg::REG_INSTR);
    // Word dropped and error flagged when full
    assign push = instrWrite & ~full;
    assign pSlverr = instrWrite & full;

    // FIFO storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr[PTR_W-1:0]] <= pWdata[pipePkg::INSTR_W-1:0];
        end
    end

    // Pointers and run bit
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            run <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (qPop && qValid) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (access && pWrite && (pAddr == pipePkg::REG_CTRL)) begin
                run <= pWdata[0];
            end
        end
    end

    // Read mux
    always_comb begin
        pRdata = '0;
        case (pAddr)
            pipePkg::REG_CTRL: pRdata[0] = run;
            pipePkg::REG_STATUS: begin
                pRdata[PTR_W:0] = count;
                pRdata[pipePkg::STATUS_HALTED_BIT] = halted;
            end
            pipePkg::REG_RETIRED: pRdata = retiredCount;
            pipePkg::REG_STALLS: pRdata = stallCount;
            default: pRdata = '0;
        endcase
    end

endmodule

/* hdl/fetchDecode.sv */
`timescale 1ns/1ps

module fetchDecode (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic qValid,
    input  logic [pipePkg::INSTR_W-1:0] qInstr,
    input  logic disablePCWrite,
    input  logic disableIFIDWrite,
    input  logic setFetchNop,
    output logic qPop,
    output logic [pipePkg::OPCODE_W-1:0] opcodeF,
    output logic [pipePkg::OPCODE_W-1:0] opcodeD,
    output logic [pipePkg::REG_W-1:0] readReg1,
    output logic [pipePkg::REG_W-1:0] readReg2,
    output logic validD,
    output logic [pipePkg::PC_W-1:0] pcD,
    output logic [pipePkg::REG_W-1:0] writeRegD
);

    pipePkg::instrWord_u qWord;
    pipePkg::instrWord_u instrF;
    pipePkg::instrWord_u instrD;
    logic validF;
    logic [pipePkg::PC_W-1:0] pc;
    logic [pipePkg::PC_W-1:0] pcF;
    // Set once HALT has reached IF
    logic haltSeen;

    assign qWord = qInstr;

    // Take the queue head only when nothing holds the front end
    assign qPop = run & qValid & ~haltSeen & ~disablePCWrite & ~setFetchNop;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            haltSeen <= 1'b0;
        end else begin
            if (qPop) begin
                pc <= pc + pipePkg::PC_W'(2);
            end
            // Keeps fetch off after HALT moves on from IF
            if (opcodeF == pipePkg::OP_HALT) begin
                haltSeen <= 1'b1;
            end
        end
    end

    // IF register
    // Holds during a data stall and takes a bubble when nothing is popped
    always_ff @(posedge clk) begin
        if (reset) begin
            validF <= 1'b0;
            instrF <= pipePkg::NOP_WORD;
        end else if (!disableIFIDWrite) begin
            validF <= qPop;
            instrF <= qPop ? qWord : pipePkg::NOP_WORD;
        end
    end

    always_ff @(posedge clk) begin
        if (qPop) begin
            pcF <= pc;
        end
    end

    // IF/ID latch
    always_ff @(posedge clk) begin
        if (reset) begin
            validD <= 1'b0;
            instrD <= pipePkg::NOP_WORD;
        end else if (!disableIFIDWrite) begin
            validD <= validF;
            instrD <= instrF;
        end
    end

    always_ff @(posedge clk) begin
        if (!disableIFIDWrite) begin
            pcD <= pcF;
        end
    end

    // Field decode
    assign opcodeF = instrF.r.opcode;
    assign opcodeD = instrD.r.opcode;
    assign readReg1 = instrD.r.rs;
    assign readReg2 = instrD.r.rt;

    // Destination by opcode class
    always_comb begin
        writeRegD = '0;
        if (pipePkg::writesReg(opcodeD)) begin
            if ((opcodeD == pipePkg::OP_LBI) || (opcodeD == pipePkg::OP_SLBI)) begin
                writeRegD = instrD.i.rs;
            end else if (opcodeD[4:3] == 2'b11) begin
                writeRegD = instrD.r.rd;
            end else begin
                writeRegD = instrD.i.rt;
            end
        end
    end

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  logic clk,
    input  logic reset,
    input  logic [pipePkg::OPCODE_W-1:0] opcodeF,
    input  logic [pipePkg::OPCODE_W-1:0] opcodeD,
    input  logic [pipePkg::REG_W-1:0] readReg1,
    input  logic [pipePkg::REG_W-1:0] readReg2,
    input  logic validD,
    input  logic validE,
    input  logic [pipePkg::OPCODE_W-1:0] opcodeE,
    input  logic [pipePkg::REG_W-1:0] writeRegE,
    input  logic validM,
    input  logic [pipePkg::OPCODE_W-1:0] opcodeM,
    input  logic [pipePkg::REG_W-1:0] writeRegM,
    input  logic validW,
    input  logic [pipePkg::OPCODE_W-1:0] opcodeW,
    input  logic [pipePkg::REG_W-1:0] writeRegW,
    output logic disablePCWrite,
    output logic disableIFIDWrite,
    output logic setExNop,
    output logic setFetchNop,
    output logic stallCycle
);

    logic useRs1, useRs2;
    logic writesE, writesM, writesW;
    logic rawEx, rawMem, rawWb;
    logic exExFwd, memMemFwd, memExFwd, wbFwd;
    logic dataHazard, controlHazard;

    // Sources that ID really reads
    assign useRs1 = validD & pipePkg::usesRs(opcodeD);
    assign useRs2 = validD & pipePkg::usesRs(opcodeD) & pipePkg::usesRt(opcodeD);

    // Producers ahead of ID
    assign writesE = validE & pipePkg::writesReg(opcodeE);
    assign writesM = validM & pipePkg::writesReg(opcodeM);
    assign writesW = validW & pipePkg::writesReg(opcodeW);

    assign rawEx = writesE & ((useRs1 & (readReg1 == writeRegE))
                            | (useRs2 & (readReg2 == writeRegE)));
    assign rawMem = writesM & ((useRs1 & (readReg1 == writeRegM))
                             | (useRs2 & (readReg2 == writeRegM)));
    assign rawWb = writesW & ((useRs1 & (readReg1 == writeRegW))
                            | (useRs2 & (readReg2 == writeRegW)));

    // Load data is not ready at the end of EX
    assign exExFwd = (opcodeE != pipePkg::OP_LD);
    // Load feeding store data goes MEM to MEM
    // A hit on the store base register still needs the stall
    assign memMemFwd = (opcodeE == pipePkg::OP_LD) & (opcodeD == pipePkg::OP_ST)
                     & ~(useRs1 & (readReg1 == writeRegE));
    // Any MEM result reaches EX over the forward bus
    assign memExFwd = writesM;
    // Register file writes through to the ID read ports
    assign wbFwd = writesW;

    assign dataHazard = (rawEx & ~(exExFwd | memMemFwd))
                      | (rawMem & ~memExFwd)
                      | (rawWb & ~wbFwd);

    // Branch or jump anywhere ahead of WB
    assign controlHazard = pipePkg::isControl(opcodeF) | pipePkg::isControl(opcodeD)
                         | (validE & pipePkg::isControl(opcodeE))
                         | (validM & pipePkg::isControl(opcodeM));

    // HALT in IF stops the PC
    assign disablePCWrite = dataHazard | controlHazard | (opcodeF == pipePkg::OP_HALT);
    // Control flow keeps moving down the pipe
    assign disableIFIDWrite = dataHazard;
    assign setExNop = dataHazard;
    assign stallCycle = dataHazard;

    // Fetch bubble lags the hazard by one cycle
    // Never clobbers a real instruction held by a data stall
    always_ff @(posedge clk) begin
        if (reset) begin
            setFetchNop <= 1'b0;
        end else begin
            setFetchNop <= controlHazard & (~dataHazard | (opcodeF == pipePkg::OP_NOP));
        end
    end

endmodule

/* hdl/stageLatch.sv */
`timescale 1ns/1ps

module stageLatch (
    input  logic clk,
    input  logic reset,
    input  logic insertBubble,
    input  logic inValid,
    input  logic [pipePkg::OPCODE_W-1:0] inOpcode,
    input  logic [pipePkg::PC_W-1:0] inPc,
    input  logic [pipePkg::REG_W-1:0] inWriteReg,
    output logic valid,
    output logic [pipePkg::OPCODE_W-1:0] opcode,
    output logic [pipePkg::PC_W-1:0] pc,
    output logic [pipePkg::REG_W-1:0] writeReg
);

    // Bubble shows up as an invalid NOP
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            opcode <= pipePkg::OP_NOP;
        end else if (insertBubble) begin
            valid <= 1'b0;
            opcode <= pipePkg::OP_NOP;
        end else begin
            valid <= inValid;
            opcode <= inOpcode;
        end
    end

    // Payload follows every cycle
    always_ff @(posedge clk) begin
        pc <= inPc;
        writeReg <= inWriteReg;
    end

endmodule

/* hdl/retireStage.sv */
`timescale 1ns/1ps

module retireStage (
    input  logic clk,
    input  logic reset,
    input  logic valid,
    input  logic [pipePkg::OPCODE_W-1:0] opcode,
    input  logic stallCycle,
    output logic [pipePkg::APB_DATA_W-1:0] retiredCount,
    output logic [pipePkg::APB_DATA_W-1:0] stallCount,
    output logic halted
);

    always_ff @(posedge clk) begin
        if (reset) begin
            retiredCount <= '0;
            stallCount <= '0;
            halted <= 1'b0;
        end else begin
            // NOPs leave WB uncounted
            if (valid && (opcode != pipePkg::OP_NOP)) begin
                retiredCount <= retiredCount + 1'b1;
            end
            if (stallCycle) begin
                stallCount <= stallCount + 1'b1;
            end
            // Sticky until reset
            if (valid && (opcode == pipePkg::OP_HALT)) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* hdl/pipeCtrlTop.sv */
`timescale 1ns/1ps

module pipeCtrlTop #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic pSel,
    input  logic pEnable,
    input  logic pWrite,
    input  logic [pipePkg::APB_ADDR_W-1:0] pAddr,
    input  logic [pipePkg::APB_DATA_W-1:0] pWdata,
    output logic [pipePkg::APB_DATA_W-1:0] pRdata,
    output logic pReady,
    output logic pSlverr
);

    localparam int N = pipePkg::NUM_LATCHES;

    logic qPop, qValid, run;
    logic [pipePkg::INSTR_W-1:0] qInstr;
    logic [pipePkg::OPCODE_W-1:0] opcodeF;
    logic [pipePkg::REG_W-1:0] readReg1, readReg2;
    logic disablePCWrite, disableIFIDWrite, setExNop, setFetchNop, stallCycle;
    logic [pipePkg::APB_DATA_W-1:0] retiredCount, stallCount;
    logic halted;

    // Entry 0 is the IF/ID latch, entries 1 to N are EX, MEM and WB
    logic stValid [N+1];
    logic [pipePkg::OPCODE_W-1:0] stOpcode [N+1];
    logic [pipePkg::PC_W-1:0] stPc [N+1];
    logic [pipePkg::REG_W-1:0] stWriteReg [N+1];

    instrQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) uQueue (
        .clk(clk), .reset(reset),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWdata(pWdata),
        .pRdata(pRdata), .pReady(pReady), .pSlverr(pSlverr),
        .qPop(qPop), .qValid(qValid), .qInstr(qInstr), .run(run),
        .retiredCount(retiredCount), .stallCount(stallCount), .halted(halted)
    );

    fetchDecode uFetch (
        .clk(clk), .reset(reset), .run(run), .qValid(qValid), .qInstr(qInstr),
        .disablePCWrite(disablePCWrite), .disableIFIDWrite(disableIFIDWrite),
        .setFetchNop(setFetchNop), .qPop(qPop), .opcodeF(opcodeF),
        .opcodeD(stOpcode[0]), .readReg1(readReg1), .readReg2(readReg2),
        .validD(stValid[0]), .pcD(stPc[0]), .writeRegD(stWriteReg[0])
    );

    // EX, MEM and WB latches
    // Only EX takes the stall bubble
    for (genvar i = 0; i < N; i++) begin : gLatch
        stageLatch uLatch (
            .clk(clk), .reset(reset),
            .insertBubble((i == 0) ? setExNop : 1'b0),
            .inValid(stValid[i]), .inOpcode(stOpcode[i]),
            .inPc(stPc[i]), .inWriteReg(stWriteReg[i]),
            .valid(stValid[i+1]), .opcode(stOpcode[i+1]),
            .pc(stPc[i+1]), .writeReg(stWriteReg[i+1])
        );
    end

    hazardUnit uHazard (
        .clk(clk), .reset(reset), .opcodeF(opcodeF), .opcodeD(stOpcode[0]),
        .readReg1(readReg1), .readReg2(readReg2), .validD(stValid[0]),
        .validE(stValid[1]), .opcodeE(stOpcode[1]), .writeRegE(stWriteReg[1]),
        .validM(stValid[2]), .opcodeM(stOpcode[2]), .writeRegM(stWriteReg[2]),
        .validW(stValid[3]), .opcodeW(stOpcode[3]), .writeRegW(stWriteReg[3]),
        .disablePCWrite(disablePCWrite), .disableIFIDWrite(disableIFIDWrite),
        .setExNop(setExNop), .setFetchNop(setFetchNop), .stallCycle(stallCycle)
    );

    // WB drains every cycle
    retireStage uRetire (
        .clk(clk), .reset(reset), .valid(stValid[N]), .opcode(stOpcode[N]),
        .stallCycle(stallCycle), .retiredCount(retiredCount),
        .stallCount(stallCount), .halted(halted)
    );

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int HALF_PERIOD = 4,
    parameter int RESET_CYCLES = 10
) (
    input  logic restart,
    output logic clk,
    output logic reset
);

    int resetLeft;

    // Free running 8 ns clock
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Power-on reset
    initial begin
        reset = 1'b1;
        resetLeft = RESET_CYCLES;
    end

    // Reset counts down edges, restart reloads the count
    always @(posedge clk) begin
        if (restart) begin
            reset <= 1'b1;
            resetLeft <= RESET_CYCLES;
        end else if (resetLeft > 1) begin
            resetLeft <= resetLeft - 1;
        end else begin
            resetLeft <= 0;
            reset <= 1'b0;
        end
    end

endmodule

/* dv/pipeCtrlTb.sv */
`timescale 1ns/1ps

module pipeCtrlTb;

    localparam int QUEUE_DEPTH = 16;
    localparam int RESET_TIMEOUT = 40;
    localparam int HALT_POLLS = 200;
    localparam int MODEL_LIMIT = 1000;
    localparam int NUM_RANDOM = 24;
    localparam logic [31:0] SEED = 32'h1dd4e4eb;
    // Opcodes from the immediate and branch groups
    localparam logic [4:0] OP_ADDI = 5'b01000;
    localparam logic [4:0] OP_BEQZ = 5'b01100;

    logic clk;
    logic reset;
    logic restart;
    logic pSel;
    logic pEnable;
    logic pWrite;
    logic [pipePkg::APB_ADDR_W-1:0] pAddr;
    logic [pipePkg::APB_DATA_W-1:0] pWdata;
    logic [pipePkg::APB_DATA_W-1:0] pRdata;
    logic pReady;
    logic pSlverr;

    logic [31:0] rngState;
    // Words pushed into the queue including HALT and any trailing words
    logic [15:0] progWords [$];

    clockGen uClock (.restart(restart), .clk(clk), .reset(reset));

    pipeCtrlTop #(.QUEUE_DEPTH(QUEUE_DEPTH)) UUT (
        .clk(clk), .reset(reset),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWdata(pWdata),
        .pRdata(pRdata), .pReady(pReady), .pSlverr(pSlverr)
    );

    task automatic failRun();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected 0x%0h got 0x%0h",
                     $time, name, expected, actual);
            failRun();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Word builders through the shared instruction union
    function automatic logic [15:0] rWord(input logic [4:0] op, input logic [2:0] rs,
                                          input logic [2:0] rt, input logic [2:0] rd);
        pipePkg::instrWord_u w;
        w = '0;
        w.r.opcode = op;
        w.r.rs = rs;
        w.r.rt = rt;
        w.r.rd = rd;
        return w;
    endfunction

    function automatic logic [15:0] iWord(input logic [4:0] op, input logic [2:0] rs,
                                          input logic [2:0] rt, input logic [4:0] imm);
        pipePkg::instrWord_u w;
        w = '0;
        w.i.opcode = op;
        w.i.rs = rs;
        w.i.rt = rt;
        w.i.imm = imm;
        return w;
    endfunction

    // Only r0 to r3 so that random code reuses registers a lot
    function automatic logic [15:0] randomWord();
        logic [31:0] r;
        logic [2:0] a;
        logic [2:0] b;
        logic [2:0] c;
        r = nextRand();
        a = {1'b0, r[9:8]};
        b = {1'b0, r[11:10]};
        c = {1'b0, r[13:12]};
        case (r[3:0])
            4'd3, 4'd4, 4'd5: return iWord(pipePkg::OP_LD, a, b, r[20:16]);
            4'd6: return iWord(pipePkg::OP_ST, a, b, r[20:16]);
            4'd7: return iWord(OP_ADDI, a, b, r[20:16]);
            4'd8: return iWord(pipePkg::OP_LBI, a, 3'd0, r[20:16]);
            4'd9: return iWord(pipePkg::OP_SLBI, a, 3'd0, r[20:16]);
            4'd10: return rWord(pipePkg::OP_BTR, a, 3'd0, c);
            4'd11: return rWord(pipePkg::OP_NOP, 3'd0, 3'd0, 3'd0);
            4'd12: return iWord(pipePkg::OP_JMP, r[22:20], 3'd0, r[20:16]);
            4'd13: return iWord(OP_BEQZ, a, 3'd0, r[20:16]);
            default: return rWord(pipePkg::OP_ADD, a, b, c);
        endcase
    endfunction

    // Source and destination use of each opcode in the program mix
    function automatic logic readsRs(input logic [4:0] op);
        case (op)
            pipePkg::OP_ADD, pipePkg::OP_BTR, pipePkg::OP_LD, pipePkg::OP_ST: return 1'b1;
            pipePkg::OP_SLBI, OP_ADDI, OP_BEQZ: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic readsRt(input logic [4:0] op);
        return (op == pipePkg::OP_ADD) || (op == pipePkg::OP_ST);
    endfunction

    function automatic logic isCtl(input logic [4:0] op);
        return (op == pipePkg::OP_JMP) || (op == OP_BEQZ);
    endfunction

    function automatic logic [2:0] destOf(input logic [15:0] word);
        pipePkg::instrWord_u w;
        w = word;
        case (w.r.opcode)
            pipePkg::OP_ADD, pipePkg::OP_BTR: return w.r.rd;
            pipePkg::OP_LD, OP_ADDI: return w.i.rt;
            pipePkg::OP_LBI, pipePkg::OP_SLBI: return w.i.rs;
            default: return 3'd0;
        endcase
    endfunction

    // Cycle model from the moment run goes high with the pipe empty
    task automatic modelRun(output int retired, output int stalls, output int popped);
        int head;
        int cycles;
        logic done;
        logic haltSeen;
        logic fetchNop;
        logic validF;
        logic validD;
        logic [15:0] wordF;
        logic [15:0] wordD;
        logic [4:0] opF;
        logic [4:0] opD;
        logic vE;
        logic vM;
        logic vW;
        logic [4:0] opE;
        logic [4:0] opM;
        logic [4:0] opW;
        logic [2:0] dE;
        logic dataHaz;
        logic ctlHaz;
        logic pop;
        head = 0;
        cycles = 0;
        done = 1'b0;
        haltSeen = 1'b0;
        fetchNop = 1'b0;
        validF = 1'b0;
        validD = 1'b0;
        wordF = rWord(pipePkg::OP_NOP, 3'd0, 3'd0, 3'd0);
        wordD = wordF;
        {vE, vM, vW} = 3'b000;
        {opE, opM, opW} = {3{pipePkg::OP_NOP}};
        dE = 3'd0;
        retired = 0;
        stalls = 0;
        while (!done) begin
            cycles++;
            if (cycles > MODEL_LIMIT) begin
                $display("Pipeline model never reached HALT in WB");
                failRun();
            end
            opF = wordF[15:11];
            opD = wordD[15:11];
            if (vW && (opW != pipePkg::OP_NOP)) retired++;
            if (vW && (opW == pipePkg::OP_HALT)) done = 1'b1;
            // Only a load in EX feeding ID cannot be forwarded unless it feeds store data
            dataHaz = validD && vE && (opE == pipePkg::OP_LD)
                && ((readsRs(opD) && (wordD[10:8] == dE))
                    || (readsRt(opD) && (opD != pipePkg::OP_ST) && (wordD[7:5] == dE)));
            ctlHaz = isCtl(opF) || isCtl(opD) || (vE && isCtl(opE)) || (vM && isCtl(opM));
            pop = (head < progWords.size()) && !haltSeen && !dataHaz && !ctlHaz
                && (opF != pipePkg::OP_HALT) && !fetchNop;
            if (dataHaz) stalls++;
            // Back half of the pipe always drains
            vW = vM;
            opW = opM;
            vM = vE;
            opM = opE;
            if (dataHaz) begin
                vE = 1'b0;
                opE = pipePkg::OP_NOP;
            end else begin
                vE = validD;
                opE = opD;
                dE = destOf(wordD);
            end
            fetchNop = ctlHaz && (!dataHaz || (opF == pipePkg::OP_NOP));
            // IF and ID hold on a data stall
            if (!dataHaz) begin
                validD = validF;
                wordD = wordF;
                validF = pop;
                wordF = pop ? progWords[head] : rWord(pipePkg::OP_NOP, 3'd0, 3'd0, 3'd0);
            end
            if (pop) begin
                if (progWords[head][15:11] == pipePkg::OP_HALT) haltSeen = 1'b1;
                head++;
            end
        end
        popped = head;
    endtask

    // One APB transfer with a setup phase and a single access phase
    task automatic apbAccess(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic slverr);
        @(posedge clk);
        pSel <= 1'b1;
        pEnable <= 1'b0;
        pWrite <= write;
        pAddr <= addr;
        pWdata <= wdata;
        @(negedge clk);
        checkEqual("pReady in setup", pReady, 1'b0);
        @(posedge clk);
        pEnable <= 1'b1;
        @(negedge clk);
        // No wait states so the transfer ends at the next edge
        checkEqual("pReady in access", pReady, 1'b1);
        rdata = pRdata;
        slverr = pSlverr;
        @(posedge clk);
        pSel <= 1'b0;
        pEnable <= 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apbAccess(1'b0, addr, 32'd0, data, err);
        checkEqual("pSlverr on read", err, 1'b0);
    endtask

    task automatic pushWord(input logic [15:0] word, input logic expectErr);
        logic [31:0] unused;
        logic err;
        apbAccess(1'b1, pipePkg::REG_INSTR, {16'd0, word}, unused, err);
        checkEqual("pSlverr", err, expectErr);
    endtask

    // Fresh reset through the clock module and wait for release
    task automatic restartDut();
        int waitCycles;
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        waitCycles = 0;
        @(negedge clk);
        while (reset !== 1'b0) begin
            waitCycles++;
            if (waitCycles > RESET_TIMEOUT) begin
                $display("Reset was never released");
                failRun();
            end
            @(negedge clk);
        end
        progWords.delete();
    endtask

    task automatic loadProgram();
        logic [31:0] status;
        foreach (progWords[i]) begin
            pushWord(progWords[i], 1'b0);
        end
        apbRead(pipePkg::REG_STATUS, status);
        checkEqual("queue count after load", status, progWords.size());
    endtask

    // Set run, poll for halted, then compare the counters
    task automatic runAndCheck(input int expRetired, input int expStalls, input int expLeft);
        logic [31:0] value;
        logic [31:0] unused;
        logic err;
        int polls;
        apbAccess(1'b1, pipePkg::REG_CTRL, 32'd1, unused, err);
        checkEqual("pSlverr on run", err, 1'b0);
        polls = 0;
        apbRead(pipePkg::REG_STATUS, value);
        while (value[pipePkg::STATUS_HALTED_BIT] !== 1'b1) begin
            polls++;
            if (polls > HALT_POLLS) begin
                $display("Pipeline never reported halted");
                failRun();
            end
            apbRead(pipePkg::REG_STATUS, value);
        end
        checkEqual("queue count after halt", value,
                   (32'd1 << pipePkg::STATUS_HALTED_BIT) | 32'(expLeft));
        apbRead(pipePkg::REG_RETIRED, value);
        checkEqual("retiredCount", value, expRetired);
        apbRead(pipePkg::REG_STALLS, value);
        checkEqual("stallCount", value, expStalls);
    endtask

    function automatic int countNonNop(input int upTo);
        int n;
        n = 0;
        for (int i = 0; i < upTo; i++) begin
            if (progWords[i][15:11] != pipePkg::OP_NOP) n++;
        end
        return n;
    endfunction

    task automatic registerAccessTest();
        logic [31:0] value;
        apbRead(pipePkg::REG_RETIRED, value);
        checkEqual("retiredCount after reset", value, 32'd0);
        apbRead(pipePkg::REG_STALLS, value);
        checkEqual("stallCount after reset", value, 32'd0);
        apbRead(pipePkg::REG_STATUS, value);
        checkEqual("status after reset", value, 32'd0);
        for (int i = 0; i < 3; i++) begin
            pushWord(randomWord(), 1'b0);
            apbRead(pipePkg::REG_STATUS, value);
            checkEqual("queue count", value, i + 1);
        end
    endtask

    task automatic queueFullTest();
        logic [31:0] value;
        restartDut();
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            // Only the push past the depth is refused
            pushWord(randomWord(), i == QUEUE_DEPTH);
        end
        apbRead(pipePkg::REG_STATUS, value);
        checkEqual("queue count when full", value, QUEUE_DEPTH);
    endtask

    // No dependencies or branches and two words left behind the HALT
    task automatic independentProgramTest();
        restartDut();
        progWords.push_back(rWord(pipePkg::OP_ADD, 3'd0, 3'd0, 3'd1));
        progWords.push_back(rWord(pipePkg::OP_ADD, 3'd0, 3'd0, 3'd2));
        progWords.push_back(iWord(OP_ADDI, 3'd0, 3'd3, 5'd7));
        progWords.push_back(rWord(pipePkg::OP_NOP, 3'd0, 3'd0, 3'd0));
        progWords.push_back(iWord(pipePkg::OP_LD, 3'd0, 3'd4, 5'd2));
        progWords.push_back(iWord(pipePkg::OP_ST, 3'd0, 3'd5, 5'd4));
        progWords.push_back(iWord(pipePkg::OP_LBI, 3'd6, 3'd0, 5'd9));
        progWords.push_back(rWord(pipePkg::OP_BTR, 3'd0, 3'd0, 3'd7));
        progWords.push_back(rWord(pipePkg::OP_HALT, 3'd0, 3'd0, 3'd0));
        progWords.push_back(rWord(pipePkg::OP_ADD, 3'd1, 3'd2, 3'd3));
        progWords.push_back(iWord(pipePkg::OP_LD, 3'd1, 3'd1, 5'd0));
        loadProgram();
        runAndCheck(countNonNop(9), 0, 2);
    endtask

    // EX-EX, MEM-MEM and two load-use pairs
    task automatic forwardingTest();
        restartDut();
        progWords.push_back(rWord(pipePkg::OP_ADD, 3'd1, 3'd2, 3'd3));
        progWords.push_back(rWord(pipePkg::OP_ADD, 3'd3, 3'd3, 3'd4));
        progWords.push_back(iWord(pipePkg::OP_LD, 3'd0, 3'd5, 5'd1));
        progWords.push_back(iWord(pipePkg::OP_ST, 3'd6, 3'd5, 5'd2));
        progWords.push_back(iWord(pipePkg::OP_LD, 3'd0, 3'd1, 5'd3));
        progWords.push_back(rWord(pipePkg::OP_ADD, 3'd1, 3'd2, 3'd6));
        progWords.push_back(iWord(pipePkg::OP_LD, 3'd0, 3'd2, 5'd4));
        progWords.push_back(iWord(OP_ADDI, 3'd2, 3'd7, 5'd1));
        progWords.push_back(rWord(pipePkg::OP_ADD, 3'd7, 3'd4, 3'd0));
        progWords.push_back(rWord(pipePkg::OP_HALT, 3'd0, 3'd0, 3'd0));
        loadProgram();
        runAndCheck(countNonNop(progWords.size()), 2, 0);
    endtask

    task automatic randomProgramTest();
        int len;
        int trail;
        int expRetired;
        int expStalls;
        int popped;
        for (int p = 0; p < NUM_RANDOM; p++) begin
            restartDut();
            len = 4 + (nextRand() % (QUEUE_DEPTH - 6));
            trail = nextRand() % 3;
            for (int i = 0; i < len; i++) begin
                progWords.push_back(randomWord());
            end
            progWords.push_back(rWord(pipePkg::OP_HALT, 3'd0, 3'd0, 3'd0));
            for (int i = 0; i < trail; i++) begin
                progWords.push_back(randomWord());
            end
            modelRun(expRetired, expStalls, popped);
            loadProgram();
            runAndCheck(expRetired, expStalls, progWords.size() - popped);
        end
    endtask

    initial begin
        pSel <= 1'b0;
        pEnable <= 1'b0;
        pWrite <= 1'b0;
        pAddr <= '0;
        pWdata <= '0;
        restart <= 1'b0;
        rngState = SEED;
        restartDut();
        registerAccessTest();
        queueFullTest();
        independentProgramTest();
        forwardingTest();
        randomProgramTest();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* compile.f */
hdl/pipePkg.sv
hdl/instrQueue.sv
hdl/fetchDecode.sv
hdl/hazardUnit.sv
hdl/stageLatch.sv
hdl/retireStage.sv
hdl/pipeCtrlTop.sv
dv/clockGen.sv
dv/pipeCtrlTb.sv
